// ==== Makefile ====
SRCS := $(wildcard *.sv *.svh)

obj_dir/Vdiv_tb: $(SRCS) compile.f
	verilator --binary --assert -j 0 --top-module div_tb -f compile.f

run: obj_dir/Vdiv_tb
	./obj_dir/Vdiv_tb +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -q "^SIMULATION PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== compile.f ====
+incdir+.
div_pkg.sv
pe_msb.sv
div32_nonrestoring_skip.sv
hs_slot.sv
div_unit.sv
div_top.sv
div_chk.sv
tb_clk.sv
div_tb.sv

// ==== div32_nonrestoring_skip.sv ====
`default_nettype none

module div32_nonrestoring_skip (
    input  logic        CLK,
    input  logic        nRST,

    input  logic        clear,
    input  logic        is_signed,
    input  logic        stall_if_done,
    output logic        done,

    input  logic [31:0] a_in,
    input  logic [31:0] b_in,

    output logic [31:0] quotient,
    output logic [31:0] remainder
);

    import div_pkg::*;

    // ----------------------------------------------------------
    // state and datapath registers

    div_state_t  state;
    div_state_t  next_state;

    // operand signs and magnitudes, captured in INIT
    logic        a_neg;
    logic        b_neg;
    logic        b_zero;
    logic [32:0] a_abs;
    logic [32:0] b_abs;
    logic [32:0] b_abs_neg;

    // live magnitude of the incoming dividend
    logic [32:0] a_abs_in;

    // msb of the dividend sets where iteration starts
    logic [4:0]  msb_index;
    logic [4:0]  msb_index_in;
    logic [31:0] msb_mask;
    logic [31:0] msb_mask_in;

    logic [4:0]  count;

    // partial remainder and combined dividend / quotient shifter
    logic [32:0] acc;
    logic [32:0] next_acc;
    logic [31:0] quo;
    logic [31:0] next_quo;

    logic [32:0] shifted;
    logic [32:0] rem_fix;

    // ----------------------------------------------------------
    // operand magnitude and msb search

    always_comb begin
        if (is_signed && a_in[31]) begin
            a_abs_in = -{1'b1, a_in};
        end else begin
            a_abs_in = {1'b0, a_in};
        end
    end

    pe_msb #(
        .WIDTH(32)
    ) u_pe_msb (
        .req_vec  (a_abs_in[31:0]),
        .ack_mask (msb_mask_in),
        .ack_index(msb_index_in)
    );

    // ----------------------------------------------------------
    // sequential

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= INIT;
            count <= '0;
        end else begin
            if (clear) begin
                state <= INIT;
            end else begin
                state <= next_state;
            end

            if (state == INIT) begin
                count <= msb_index_in;
            end else if (state == ITERS) begin
                count <= count - 5'd1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        // operands sampled every INIT cycle until clear drops
        if (state == INIT) begin
            a_neg     <= is_signed & a_in[31];
            b_neg     <= is_signed & b_in[31];
            b_zero    <= (b_in == 32'd0);
            a_abs     <= a_abs_in;
            msb_index <= msb_index_in;
            msb_mask  <= msb_mask_in;
            if (is_signed && b_in[31]) begin
                b_abs     <= -{1'b1, b_in};
                b_abs_neg <= {1'b1, b_in};
            end else begin
                b_abs     <= {1'b0, b_in};
                b_abs_neg <= -{1'b0, b_in};
            end
        end
        acc <= next_acc;
        quo <= next_quo;
    end

    // ----------------------------------------------------------
    // next state and datapath

    always_comb begin
        next_state = state;
        next_acc   = acc;
        next_quo   = quo;
        done       = 1'b0;

        // bring down the next dividend bit
        shifted = {acc[31:0], quo[msb_index]};
        // add back the divisor if the final remainder went negative
        rem_fix = acc + (b_abs & {33{acc[32]}});

        case (state)
            INIT: begin
                next_state = ITERS;
                next_acc   = '0;
                next_quo   = a_abs_in[31:0];
            end

            ITERS: begin
                if (b_zero) begin
                    next_state = DONE;
                    next_acc   = {1'b0, a_in};
                    next_quo   = '1;
                end else if (a_abs < b_abs) begin
                    // quotient is zero, remainder is the dividend itself
                    next_state = DONE;
                    next_acc   = {1'b0, a_in};
                    next_quo   = '0;
                end else begin
                    if (count == 5'd0) begin
                        next_state = CORRECTION;
                    end
                    if (acc[32]) begin
                        next_acc = shifted + b_abs;
                    end else begin
                        next_acc = shifted + b_abs_neg;
                    end
                    next_quo = {quo[30:0], ~next_acc[32]} & msb_mask;
                end
            end

            CORRECTION: begin
                next_state = DONE;
                // remainder follows the dividend sign
                if (a_neg) begin
                    next_acc = -rem_fix;
                end else begin
                    next_acc = rem_fix;
                end
                if (a_neg ^ b_neg) begin
                    next_quo = -quo;
                end
            end

            DONE: begin
                done = 1'b1;
                if (!stall_if_done) begin
                    next_state = INIT;
                end
            end

            default: begin
                next_state = INIT;
            end
        endcase
    end

    assign quotient  = quo;
    assign remainder = acc[31:0];

endmodule

`default_nettype wire

// ==== div_chk.sv ====
`default_nettype none

module div_chk (
    input logic               CLK,
    input logic               nRST,
    input logic               in_req,
    input div_pkg::div_req_t  in,
    input logic               in_ack,
    input logic               out_req,
    input div_pkg::div_resp_t out,
    input logic               out_ack,
    input logic               div_done
);

    import div_pkg::*;

    int unsigned err_count = 0;

    logic [31:0] expect_tbl [16];
    div_op_t     op_tbl [16];
    logic [3:0]  order_q [16];
    logic [3:0]  wr_ptr;
    logic [3:0]  rd_ptr;
    logic        in_ack_q;
    logic        out_ack_q;
    int          outstanding;

    logic        captured;
    logic        released;
    logic [31:0] exp_now;
    div_op_t     op_now;
    logic [3:0]  tag_now;

    // RISC-V M-extension reference for one request
    function automatic logic [31:0] riscv_result(input div_req_t r);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               ovf;
        sa  = r.a;
        sb  = r.b;
        ovf = (r.a == 32'h8000_0000) && (r.b == 32'hffff_ffff);
        case (r.op)
            OP_DIVU: return (r.b == 32'd0) ? 32'hffff_ffff : r.a / r.b;
            OP_REMU: return (r.b == 32'd0) ? r.a : r.a % r.b;
            OP_DIV: begin
                if (r.b == 32'd0) return 32'hffff_ffff;
                else if (ovf) return 32'h8000_0000;
                else return sa / sb;
            end
            default: begin
                if (r.b == 32'd0) return r.a;
                else if (ovf) return 32'd0;
                else return sa % sb;
            end
        endcase
    endfunction

    function automatic string op_name(input div_op_t op);
        case (op)
            OP_DIV:  return "DIV";
            OP_DIVU: return "DIVU";
            OP_REM:  return "REM";
            default: return "REMU";
        endcase
    endfunction

    // ------------------------------------------------------------
    // request bookkeeping by tag, in arrival order

    assign captured = in_ack & ~in_ack_q;
    assign released = out_ack & ~out_ack_q;
    assign exp_now  = expect_tbl[out.tag];
    assign op_now   = op_tbl[out.tag];
    assign tag_now  = order_q[rd_ptr];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            in_ack_q    <= 1'b0;
            out_ack_q   <= 1'b0;
            outstanding <= 0;
        end else begin
            in_ack_q  <= in_ack;
            out_ack_q <= out_ack;
            if (captured) begin
                expect_tbl[in.tag] <= riscv_result(in);
                op_tbl[in.tag]     <= in.op;
                order_q[wr_ptr]    <= in.tag;
                wr_ptr             <= wr_ptr + 4'd1;
            end
            if (released) begin
                rd_ptr <= rd_ptr + 4'd1;
            end
            outstanding <= outstanding + (captured ? 1 : 0) - (released ? 1 : 0);
        end
    end

    // ------------------------------------------------------------
    // assertions

    a_result: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(out_req) |-> out.result == exp_now)
    else begin
        $error("FAILED %s tag %0d: expected %h, actual %h",
               op_name(op_now), out.tag, exp_now, out.result);
        err_count++;
    end

    a_tag_order: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(out_req) |-> out.tag == tag_now)
    else begin
        $error("FAILED tag order: expected %0d, actual %0d", tag_now, out.tag);
        err_count++;
    end

    a_out_stable: assert property (@(posedge CLK) disable iff (!nRST)
        out_req && $past(out_req) |-> $stable(out))
    else begin
        $error("response changed while out_req was high");
        err_count++;
    end

    a_ack_rise: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(in_ack) |-> $past(in_req))
    else begin
        $error("in_ack rose without in_req");
        err_count++;
    end

    a_ack_fall: assert property (@(posedge CLK) disable iff (!nRST)
        $fell(in_ack) |-> !$past(in_req))
    else begin
        $error("in_ack fell while in_req was still high");
        err_count++;
    end

    // at most one response waiting plus one request held
    a_in_flight: assert property (@(posedge CLK) disable iff (!nRST)
        outstanding <= 2)
    else begin
        $error("a third request was accepted under back-pressure");
        err_count++;
    end

    a_reset: assert property (@(posedge CLK)
        !nRST |-> !in_ack && !out_req && !div_done)
    else begin
        $error("handshake outputs not low during reset");
        err_count++;
    end

endmodule

bind div_top div_chk u_chk (
    .CLK     (CLK),
    .nRST    (nRST),
    .in_req  (in_req),
    .in      (in),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out     (out),
    .out_ack (out_ack),
    .div_done(div_done)
);

`default_nettype wire

// ==== div_defines.svh ====
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// operand and result width
`define DIV_XLEN 32

// request tag, carried unchanged to the response
`define DIV_TAG_W 4

// operation select width, four M-extension divide ops
`define DIV_OP_W 2

// divider FSM state encoding width
`define DIV_STATE_W 2

`endif

// ==== div_pkg.sv ====
`default_nettype none

`include "div_defines.svh"

package div_pkg;

    typedef enum logic [`DIV_OP_W-1:0] {
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } div_op_t;

    // divider sequencing
    typedef enum logic [`DIV_STATE_W-1:0] {
        INIT,
        ITERS,
        CORRECTION,
        DONE
    } div_state_t;

    typedef struct packed {
        div_op_t               op;
        logic [`DIV_XLEN-1:0]  a;
        logic [`DIV_XLEN-1:0]  b;
        logic [`DIV_TAG_W-1:0] tag;
    } div_req_t;

    typedef struct packed {
        logic [`DIV_XLEN-1:0]  result;
        logic [`DIV_TAG_W-1:0] tag;
    } div_resp_t;

endpackage

`default_nettype wire

// ==== div_tb.sv ====
`default_nettype none

`include "div_defines.svh"

module div_tb;

    import div_pkg::*;

    localparam int N_REQ   = 38;
    localparam int TIMEOUT = 40 * N_REQ + 200;

    logic     CLK;
    logic     nRST = 1'b0;
    logic     in_req = 1'b0;
    div_req_t in_data = '0;
    logic     in_ack;
    logic     out_req;
    div_resp_t out_data;
    logic     out_ack = 1'b0;

    int          seed = 32'h94a5;
    int          cycles = 0;
    int          req_count = 0;
    int          resp_count = 0;
    int          tests = 0;
    int          fails = 0;
    int unsigned err_mark = 0;
    int          ack_wait = 3;
    logic        hold_ack = 1'b0;
    logic [`DIV_TAG_W-1:0] next_tag = '0;

    tb_clk #(
        .PERIOD(100)
    ) u_clk (
        .CLK(CLK)
    );

    div_top u_div_top (
        .CLK    (CLK),
        .nRST   (nRST),
        .in_req (in_req),
        .in     (in_data),
        .in_ack (in_ack),
        .out_req(out_req),
        .out    (out_data),
        .out_ack(out_ack)
    );

    // ------------------------------------------------------------
    // four-phase producer, entered right after a rising edge

    task automatic offer(input div_op_t op, input logic [31:0] a, input logic [31:0] b);
        in_data.op  <= op;
        in_data.a   <= a;
        in_data.b   <= b;
        in_data.tag <= next_tag;
        in_req      <= 1'b1;
        next_tag    <= next_tag + 4'd1;
    endtask

    task automatic complete();
        @(posedge CLK);
        while (!in_ack) @(posedge CLK);
        in_req <= 1'b0;
        @(posedge CLK);
        while (in_ack) @(posedge CLK);
        req_count++;
    endtask

    task automatic send(input div_op_t op, input logic [31:0] a, input logic [31:0] b);
        offer(op, a, b);
        complete();
    endtask

    task automatic send_all_ops(input logic [31:0] a, input logic [31:0] b);
        send(OP_DIV, a, b);
        send(OP_DIVU, a, b);
        send(OP_REM, a, b);
        send(OP_REMU, a, b);
    endtask

    task automatic end_test(input string name);
        int unsigned errs;
        while (resp_count != req_count) @(posedge CLK);
        repeat (4) @(posedge CLK);
        errs = u_div_top.u_chk.err_count - err_mark;
        err_mark = u_div_top.u_chk.err_count;
        tests++;
        if (errs == 0) begin
            $display("test %s passed", name);
        end else begin
            $display("FAILED %s: expected 0 assertion failures, actual %0d", name, errs);
            fails++;
        end
    endtask

    // ------------------------------------------------------------
    // consumer with a random ack delay

    always @(posedge CLK) begin
        if (!nRST) begin
            out_ack <= 1'b0;
        end else if (out_ack) begin
            if (!out_req) begin
                out_ack <= 1'b0;
            end
        end else if (out_req && !hold_ack) begin
            if (ack_wait == 0) begin
                out_ack    <= 1'b1;
                resp_count <= resp_count + 1;
                ack_wait   <= $unsigned($random(seed)) % 8;
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, %0d of %0d responses seen",
                     cycles, resp_count, req_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus

    initial begin
        logic [31:0] a;
        logic [31:0] b;

        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        repeat (2) @(posedge CLK);

        send(OP_DIVU, 32'd100, 32'd7);
        end_test("reset_handshake");

        for (int i = 0; i < 6; i++) begin
            a = $random(seed);
            b = $random(seed);
            // a few narrow divisors for long quotients
            if (i < 2) b = b >> 20;
            send(OP_DIVU, a, b);
            send(OP_REMU, a, b);
        end
        end_test("unsigned");

        for (int s = 0; s < 4; s++) begin
            a = $unsigned($random(seed)) >> 1;
            b = ($unsigned($random(seed)) >> 18) | 32'd1;
            if (s[0]) a = -a;
            if (s[1]) b = -b;
            send(OP_DIV, a, b);
            send(OP_REM, a, b);
        end
        // small dividends take the early exit
        send(OP_DIV, 32'd5, -32'd9);
        send(OP_REM, 32'd5, -32'd9);
        send(OP_DIV, -32'd5, 32'd9);
        send(OP_REM, -32'd5, 32'd9);
        end_test("signed");

        a = $random(seed);
        send_all_ops(a, 32'd0);
        send_all_ops(32'hffff_f000, 32'd0);
        end_test("divide_by_zero");

        send(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        send(OP_REM, 32'h8000_0000, 32'hffff_ffff);
        end_test("signed_overflow");

        hold_ack <= 1'b1;
        send(OP_DIVU, 32'hdead_beef, 32'd3);
        send(OP_REM, -32'd1000, 32'd7);
        offer(OP_DIV, 32'd77, 32'd5);
        repeat (60) @(posedge CLK);
        hold_ack <= 1'b0;
        complete();
        end_test("back_pressure");

        $display("%0d tests, %0d failed, %0d assertion failures",
                 tests, fails, u_div_top.u_chk.err_count);
        if (fails == 0 && u_div_top.u_chk.err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== div_top.sv ====
`default_nettype none

module div_top (
    input  logic               CLK,
    input  logic               nRST,

    input  logic               in_req,
    input  div_pkg::div_req_t  in,
    output logic               in_ack,

    output logic               out_req,
    output div_pkg::div_resp_t out,
    input  logic               out_ack
);

    import div_pkg::*;

    logic        req_full;
    logic        req_take;
    div_req_t    req_held;

    logic        resp_full;
    logic        resp_load;
    div_resp_t   resp_data;

    logic        div_clear;
    logic        div_is_signed;
    logic        div_stall;
    logic        div_done;
    logic [31:0] div_a;
    logic [31:0] div_b;
    logic [31:0] div_quotient;
    logic [31:0] div_remainder;

    // request side, load and presentation tied off
    hs_slot #(
        .T(div_req_t)
    ) u_req_slot (
        .CLK      (CLK),
        .nRST     (nRST),
        .up_req   (in_req),
        .up_data  (in),
        .up_ack   (in_ack),
        .full     (req_full),
        .held     (req_held),
        .take     (req_take),
        .down_load(1'b0),
        .down_data('0),
        .dn_req   (),
        .dn_ack   (1'b0)
    );

    div_unit u_div_unit (
        .CLK          (CLK),
        .nRST         (nRST),
        .req_full     (req_full),
        .req          (req_held),
        .req_take     (req_take),
        .resp_full    (resp_full),
        .resp_load    (resp_load),
        .resp         (resp_data),
        .div_clear    (div_clear),
        .div_is_signed(div_is_signed),
        .div_stall    (div_stall),
        .div_done     (div_done),
        .div_a        (div_a),
        .div_b        (div_b),
        .div_quotient (div_quotient),
        .div_remainder(div_remainder)
    );

    div32_nonrestoring_skip u_div (
        .CLK          (CLK),
        .nRST         (nRST),
        .clear        (div_clear),
        .is_signed    (div_is_signed),
        .stall_if_done(div_stall),
        .done         (div_done),
        .a_in         (div_a),
        .b_in         (div_b),
        .quotient     (div_quotient),
        .remainder    (div_remainder)
    );

    // response side, capture and take tied off
    hs_slot #(
        .T(div_resp_t)
    ) u_resp_slot (
        .CLK      (CLK),
        .nRST     (nRST),
        .up_req   (1'b0),
        .up_data  ('0),
        .up_ack   (),
        .full     (resp_full),
        .held     (out),
        .take     (1'b0),
        .down_load(resp_load),
        .down_data(resp_data),
        .dn_req   (out_req),
        .dn_ack   (out_ack)
    );

endmodule

`default_nettype wire

// ==== div_unit.sv ====
`default_nettype none

module div_unit (
    input  logic               CLK,
    input  logic               nRST,

    // request slot
    input  logic               req_full,
    input  div_pkg::div_req_t  req,
    output logic               req_take,

    // response slot
    input  logic               resp_full,
    output logic               resp_load,
    output div_pkg::div_resp_t resp,

    // divider control
    output logic               div_clear,
    output logic               div_is_signed,
    output logic               div_stall,
    input  logic               div_done,

    // divider data
    output logic [31:0]        div_a,
    output logic [31:0]        div_b,
    input  logic [31:0]        div_quotient,
    input  logic [31:0]        div_remainder
);

    import div_pkg::*;

    logic busy;
    logic finish;
    logic sel_rem;

    // ----------------------------------------------------------
    // sequencing

    // result handed off only when the response slot has room
    assign finish = busy & div_done & ~resp_full;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
        end else begin
            if (!busy && req_full) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
            end
        end
    end

    // divider parked in INIT while idle and on hand-off
    assign div_clear = ~busy | finish;
    assign div_stall = resp_full;

    assign req_take  = finish;
    assign resp_load = finish;

    // ----------------------------------------------------------
    // decode and result select

    always_comb begin
        div_is_signed = (req.op == OP_DIV) || (req.op == OP_REM);
        sel_rem       = (req.op == OP_REM) || (req.op == OP_REMU);
    end

    assign div_a = req.a;
    assign div_b = req.b;

    always_comb begin
        resp.tag = req.tag;
        if (sel_rem) begin
            resp.result = div_remainder;
        end else begin
            resp.result = div_quotient;
        end
    end

endmodule

`default_nettype wire

// ==== hs_slot.sv ====
`default_nettype none

module hs_slot #(
    parameter type T = logic
) (
    input  logic CLK,
    input  logic nRST,

    // four-phase capture side
    input  logic up_req,
    input  T     up_data,
    output logic up_ack,

    // local valid/take view of the stored entry
    output logic full,
    output T     held,
    input  logic take,

    // local load and four-phase presentation side
    input  logic down_load,
    input  T     down_data,
    output logic dn_req,
    input  logic dn_ack
);

    logic valid;
    logic dn_wait;
    logic capture;

    // new capture only once the previous ack has dropped
    assign capture = up_req & ~up_ack & ~full;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid   <= 1'b0;
            up_ack  <= 1'b0;
            dn_wait <= 1'b0;
        end else begin
            if (capture || down_load) begin
                valid <= 1'b1;
            end else if (take || (valid && dn_ack)) begin
                valid <= 1'b0;
            end

            if (capture) begin
                up_ack <= 1'b1;
            end else if (!up_req) begin
                up_ack <= 1'b0;
            end

            // hold off the next presentation until ack returns low
            if (valid && dn_ack) begin
                dn_wait <= 1'b1;
            end else if (!dn_ack) begin
                dn_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            held <= up_data;
        end else if (down_load) begin
            held <= down_data;
        end
    end

    assign full   = valid | dn_wait;
    assign dn_req = valid;

endmodule

`default_nettype wire

// ==== pe_msb.sv ====
`default_nettype none

module pe_msb #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]         req_vec,
    output logic [WIDTH-1:0]         ack_mask,
    output logic [$clog2(WIDTH)-1:0] ack_index
);

    localparam int IDX_W = $clog2(WIDTH);

    // highest set bit wins, scanning upward
    always_comb begin
        ack_index = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (req_vec[i]) begin
                ack_index = IDX_W'(i);
            end
        end
    end

    // smear the top set bit down to bit zero
    always_comb begin
        logic seen;
        seen = 1'b0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            seen = seen | req_vec[i];
            ack_mask[i] = seen;
        end
        // all-zero input still keeps bit zero in the mask
        ack_mask[0] = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_clk.sv ====
`default_nettype none

module tb_clk #(
    parameter int PERIOD = 100
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD / 2) CLK = ~CLK;
        end
    end

endmodule

`default_nettype wire
